// File: verilog/softusb_macros.svh
`ifndef SOFTUSB_MACROS_SVH
`define SOFTUSB_MACROS_SVH

// Program memory, 16-bit words.
`define SOFTUSB_PMEM_AW 11	// Word address width.

// Data memory, four byte lanes.
`define SOFTUSB_DMEM_AW 13	// Byte address width, core side.
`define SOFTUSB_DMEM_WAW 11	// Word address width, host side.

// Host address map.
`define SOFTUSB_DSEL_BIT 17	// Set selects data memory.

`endif

// File: verilog/softusb_pkg.sv
`default_nettype none

`include "softusb_macros.svh"

package softusb_pkg;

	// Host bus.
	typedef logic [31:0] axil_addr_t;	// Byte address.
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0] axil_strb_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'b00;

	// Program memory.
	typedef logic [15:0] pmem_word_t;
	typedef logic [`SOFTUSB_PMEM_AW-1:0] pmem_addr_t;

	// Data memory.
	typedef logic [7:0] dmem_byte_t;
	typedef logic [`SOFTUSB_DMEM_AW-1:0] dmem_addr_t;	// Core byte address.
	typedef logic [`SOFTUSB_DMEM_WAW-1:0] dmem_waddr_t;	// Word address.

	// Host bus FSM.
	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP,
		READ_DATA
	} bus_state_t;

endpackage

`default_nettype wire

// File: verilog/mem_access_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_access_if;
	import softusb_pkg::*;

	logic pmem_we;		// Program memory write.
	logic dmem_we;		// Data memory write, lanes per wstrb.
	dmem_waddr_t addr;	// Shared word address.
	axil_data_t wdata;
	axil_strb_t wstrb;

	// Registered, valid one cycle after addr.
	pmem_word_t pmem_rdata;
	axil_data_t dmem_rdata;

	modport ctrl (
		output pmem_we, dmem_we, addr, wdata, wstrb,
		input pmem_rdata, dmem_rdata
	);

	modport mem (
		input pmem_we, dmem_we, addr, wdata, wstrb,
		output pmem_rdata, dmem_rdata
	);

endinterface

`default_nettype wire

// File: verilog/softusb_axil_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "softusb_macros.svh"

module softusb_axil_fsm (
	input wire logic sys_clk,
	input wire logic sys_rst,
	input wire logic mem_ready_i,

	input wire softusb_pkg::axil_addr_t awaddr_i,
	input wire logic awvalid_i,
	output logic awready_o,
	input wire softusb_pkg::axil_data_t wdata_i,
	input wire softusb_pkg::axil_strb_t wstrb_i,
	input wire logic wvalid_i,
	output logic wready_o,
	output logic bvalid_o,
	output softusb_pkg::axil_resp_t bresp_o,
	input wire logic bready_i,

	input wire softusb_pkg::axil_addr_t araddr_i,
	input wire logic arvalid_i,
	output logic arready_o,
	output logic rvalid_o,
	output softusb_pkg::axil_data_t rdata_o,
	output softusb_pkg::axil_resp_t rresp_o,
	input wire logic rready_i,

	mem_access_if.ctrl mem
);
	import softusb_pkg::*;

	bus_state_t state_q;
	bus_state_t state_d;

	logic write_pending;
	logic wr_hs;
	logic rd_hs;

	logic rd_dsel_q;	// Read targets data memory.
	logic rd_fresh_q;	// First READ_DATA cycle, RAM output live.
	axil_data_t rd_word;
	axil_data_t rdata_q;

	assign write_pending = awvalid_i | wvalid_i;

	// Both write channels are taken in one go.
	assign wr_hs = (state_q == IDLE) & awvalid_i & wvalid_i & mem_ready_i;
	assign rd_hs = (state_q == IDLE) & arvalid_i & mem_ready_i & ~write_pending;

	assign awready_o = wr_hs;
	assign wready_o = wr_hs;
	assign arready_o = rd_hs;

	// Memory access in the handshake cycle.
	assign mem.addr = wr_hs ? awaddr_i[`SOFTUSB_DMEM_AW-1:2] : araddr_i[`SOFTUSB_DMEM_AW-1:2];
	assign mem.pmem_we = wr_hs & ~awaddr_i[`SOFTUSB_DSEL_BIT];
	assign mem.dmem_we = wr_hs & awaddr_i[`SOFTUSB_DSEL_BIT];
	assign mem.wdata = wdata_i;
	assign mem.wstrb = wstrb_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (wr_hs)
					state_d = WRITE_RESP;
				else if (rd_hs)
					state_d = READ_DATA;
			end
			WRITE_RESP: begin
				if (bready_i)
					state_d = IDLE;
			end
			READ_DATA: begin
				if (rready_i)
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= IDLE;
			rd_fresh_q <= 1'b0;
		end else begin
			state_q <= state_d;
			rd_fresh_q <= rd_hs;
		end
	end

	// Program words are zero-extended.
	assign rd_word = rd_dsel_q ? mem.dmem_rdata : {16'h0000, mem.pmem_rdata};

	always_ff @(posedge sys_clk) begin
		if (rd_hs)
			rd_dsel_q <= araddr_i[`SOFTUSB_DSEL_BIT];
		if (rd_fresh_q)
			rdata_q <= rd_word;	// Hold under back-pressure.
	end

	assign rdata_o = rd_fresh_q ? rd_word : rdata_q;
	assign rvalid_o = (state_q == READ_DATA);
	assign bvalid_o = (state_q == WRITE_RESP);
	assign bresp_o = RESP_OKAY;
	assign rresp_o = RESP_OKAY;

	a_one_resp: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!(bvalid_o && rvalid_o));

	a_r_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

`default_nettype wire

// File: verilog/softusb_clear_timer.sv
`timescale 1ns/100ps
`default_nettype none

module softusb_clear_timer (
	input wire logic sys_clk,
	input wire logic sys_rst,
	output logic clr_we_o,
	output softusb_pkg::dmem_waddr_t clr_addr_o,
	output logic mem_ready_o
);
	import softusb_pkg::*;

	dmem_waddr_t cnt_q;
	logic running_q;
	logic last_word;

	assign last_word = (cnt_q == '1);

	// Sweep begins straight out of reset.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cnt_q <= '0;
			running_q <= 1'b1;
			mem_ready_o <= 1'b0;
		end else if (running_q) begin
			cnt_q <= cnt_q + dmem_waddr_t'(1);
			if (last_word) begin
				running_q <= 1'b0;
				mem_ready_o <= 1'b1;	// One cycle after final write.
			end
		end
	end

	assign clr_we_o = running_q;
	assign clr_addr_o = cnt_q;

	a_clear_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!(clr_we_o && mem_ready_o));

endmodule

`default_nettype wire

// File: verilog/softusb_pmem.sv
`timescale 1ns/100ps
`default_nettype none

`include "softusb_macros.svh"

module softusb_pmem (
	input wire logic sys_clk,

	mem_access_if.mem host,

	input wire logic pmem_ce_i,
	input wire softusb_pkg::pmem_addr_t pmem_a_i,
	output softusb_pkg::pmem_word_t pmem_d_o
);
	import softusb_pkg::*;

	localparam int DEPTH = 1 << `SOFTUSB_PMEM_AW;

	pmem_word_t ram [0:DEPTH-1];
	pmem_addr_t host_addr;

	assign host_addr = host.addr[`SOFTUSB_PMEM_AW-1:0];	// Low word bits only.

	// Host port, read-first.
	always_ff @(posedge sys_clk) begin
		if (host.pmem_we)
			ram[host_addr] <= host.wdata[15:0];
		host.pmem_rdata <= ram[host_addr];
	end

	// Fetch port holds without a clock enable.
	always_ff @(posedge sys_clk) begin
		if (pmem_ce_i)
			pmem_d_o <= ram[pmem_a_i];
	end

endmodule

`default_nettype wire

// File: verilog/softusb_dmem.sv
`timescale 1ns/100ps
`default_nettype none

`include "softusb_macros.svh"

module softusb_dmem (
	input wire logic sys_clk,

	mem_access_if.mem host,

	input wire logic clr_we_i,
	input wire softusb_pkg::dmem_waddr_t clr_addr_i,
	input wire logic mem_ready_i,

	input wire logic dmem_we_i,
	input wire softusb_pkg::dmem_addr_t dmem_a_i,
	input wire softusb_pkg::dmem_byte_t dmem_di_i,
	output softusb_pkg::dmem_byte_t dmem_do_o
);
	import softusb_pkg::*;

	localparam int DEPTH = 1 << `SOFTUSB_DMEM_WAW;

	dmem_waddr_t core_waddr;
	dmem_byte_t core_wdata;
	dmem_waddr_t core_raddr;
	logic [1:0] lane_sel_q;		// Byte offset of last core read.

	dmem_byte_t host_do [4];
	dmem_byte_t core_do [4];

	// Clear owns the core write path until ready.
	assign core_waddr = mem_ready_i ? dmem_a_i[`SOFTUSB_DMEM_AW-1:2] : clr_addr_i;
	assign core_wdata = mem_ready_i ? dmem_di_i : '0;
	assign core_raddr = dmem_a_i[`SOFTUSB_DMEM_AW-1:2];

	for (genvar g = 0; g < 4; g++) begin : g_lane
		dmem_byte_t ram [0:DEPTH-1];
		dmem_byte_t host_q;
		dmem_byte_t core_q;
		logic host_we;
		logic core_we;

		assign host_we = host.dmem_we & host.wstrb[g];
		// Byte offset 0 lives in the top lane.
		assign core_we = clr_we_i | (mem_ready_i & dmem_we_i & (dmem_a_i[1:0] == 2'(3 - g)));

		always_ff @(posedge sys_clk) begin
			if (host_we)
				ram[host.addr] <= host.wdata[8*g +: 8];
			if (core_we)
				ram[core_waddr] <= core_wdata;
			host_q <= ram[host.addr];
			core_q <= ram[core_raddr];
		end

		assign host_do[g] = host_q;
		assign core_do[g] = core_q;
	end

	assign host.dmem_rdata = {host_do[3], host_do[2], host_do[1], host_do[0]};

	always_ff @(posedge sys_clk) begin
		lane_sel_q <= ~dmem_a_i[1:0];	// Inverted offset gives lane.
	end

	assign dmem_do_o = core_do[lane_sel_q];

endmodule

`default_nettype wire

// File: verilog/softusb_ram_top.sv
`timescale 1ns/100ps
`default_nettype none

module softusb_ram_top (
	input wire logic sys_clk,
	input wire logic sys_rst,

	input wire softusb_pkg::axil_addr_t s_axil_awaddr_i,
	input wire logic s_axil_awvalid_i,
	output logic s_axil_awready_o,
	input wire softusb_pkg::axil_data_t s_axil_wdata_i,
	input wire softusb_pkg::axil_strb_t s_axil_wstrb_i,
	input wire logic s_axil_wvalid_i,
	output logic s_axil_wready_o,
	output logic s_axil_bvalid_o,
	output softusb_pkg::axil_resp_t s_axil_bresp_o,
	input wire logic s_axil_bready_i,
	input wire softusb_pkg::axil_addr_t s_axil_araddr_i,
	input wire logic s_axil_arvalid_i,
	output logic s_axil_arready_o,
	output logic s_axil_rvalid_o,
	output softusb_pkg::axil_data_t s_axil_rdata_o,
	output softusb_pkg::axil_resp_t s_axil_rresp_o,
	input wire logic s_axil_rready_i,

	output logic mem_ready_o,

	input wire logic pmem_ce_i,
	input wire softusb_pkg::pmem_addr_t pmem_a_i,
	output softusb_pkg::pmem_word_t pmem_d_o,

	input wire logic dmem_we_i,
	input wire softusb_pkg::dmem_addr_t dmem_a_i,
	input wire softusb_pkg::dmem_byte_t dmem_di_i,
	output softusb_pkg::dmem_byte_t dmem_do_o
);
	import softusb_pkg::*;

	logic clr_we;
	dmem_waddr_t clr_addr;

	mem_access_if u_mem_if ();

	softusb_axil_fsm u_axil_fsm (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.mem_ready_i(mem_ready_o),
		.awaddr_i(s_axil_awaddr_i),
		.awvalid_i(s_axil_awvalid_i),
		.awready_o(s_axil_awready_o),
		.wdata_i(s_axil_wdata_i),
		.wstrb_i(s_axil_wstrb_i),
		.wvalid_i(s_axil_wvalid_i),
		.wready_o(s_axil_wready_o),
		.bvalid_o(s_axil_bvalid_o),
		.bresp_o(s_axil_bresp_o),
		.bready_i(s_axil_bready_i),
		.araddr_i(s_axil_araddr_i),
		.arvalid_i(s_axil_arvalid_i),
		.arready_o(s_axil_arready_o),
		.rvalid_o(s_axil_rvalid_o),
		.rdata_o(s_axil_rdata_o),
		.rresp_o(s_axil_rresp_o),
		.rready_i(s_axil_rready_i),
		.mem(u_mem_if.ctrl)
	);

	softusb_clear_timer u_clear_timer (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.clr_we_o(clr_we),
		.clr_addr_o(clr_addr),
		.mem_ready_o(mem_ready_o)
	);

	softusb_pmem u_pmem (
		.sys_clk(sys_clk),
		.host(u_mem_if.mem),
		.pmem_ce_i(pmem_ce_i),
		.pmem_a_i(pmem_a_i),
		.pmem_d_o(pmem_d_o)
	);

	softusb_dmem u_dmem (
		.sys_clk(sys_clk),
		.host(u_mem_if.mem),
		.clr_we_i(clr_we),
		.clr_addr_i(clr_addr),
		.mem_ready_i(mem_ready_o),
		.dmem_we_i(dmem_we_i),
		.dmem_a_i(dmem_a_i),
		.dmem_di_i(dmem_di_i),
		.dmem_do_o(dmem_do_o)
	);

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
	output logic sys_clk,
	output logic sys_rst
);
	localparam int HALF_PERIOD = 4;	// 8 ns clock.
	localparam int RESET_CYCLES = 4;

	initial begin
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;	// Released on a falling edge.
	end

	always #HALF_PERIOD sys_clk = ~sys_clk;

endmodule

`default_nettype wire

// File: verif/tb_softusb_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "softusb_macros.svh"

module tb_softusb_ram;
	import softusb_pkg::*;

	localparam int TIMEOUT = 64;		// Cycles per handshake.
	localparam int CLEAR_TIMEOUT = 4096;
	localparam int DWORDS = 1 << `SOFTUSB_DMEM_WAW;

	logic sys_clk, sys_rst;
	axil_addr_t awaddr, araddr;
	axil_data_t wdata, rdata;
	axil_strb_t wstrb;
	axil_resp_t bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready, mem_ready;
	logic pmem_ce, dmem_we;
	pmem_addr_t pmem_a;
	pmem_word_t pmem_d;
	dmem_addr_t dmem_a;
	dmem_byte_t dmem_di, dmem_do;

	pmem_word_t pmem_model [0:DWORDS-1];
	dmem_byte_t dmem_model [0:3][0:DWORDS-1];	// Lane 3 holds byte offset 0.

	logic [31:0] rnd;
	axil_data_t got, data;
	pmem_word_t word;
	dmem_waddr_t w;
	dmem_addr_t a;
	dmem_byte_t b;
	int n;

	tb_clk_gen u_clk_gen (.sys_clk(sys_clk), .sys_rst(sys_rst));

	softusb_ram_top u_dut (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
		.s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
		.s_axil_wready_o(wready), .s_axil_bvalid_o(bvalid), .s_axil_bresp_o(bresp),
		.s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
		.s_axil_arready_o(arready), .s_axil_rvalid_o(rvalid), .s_axil_rdata_o(rdata),
		.s_axil_rresp_o(rresp), .s_axil_rready_i(rready), .mem_ready_o(mem_ready),
		.pmem_ce_i(pmem_ce), .pmem_a_i(pmem_a), .pmem_d_o(pmem_d),
		.dmem_we_i(dmem_we), .dmem_a_i(dmem_a), .dmem_di_i(dmem_di), .dmem_do_o(dmem_do)
	);

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s.", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input axil_data_t actual, input axil_data_t expected,
			input string what);
		if (actual !== expected) begin
			$display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	function automatic axil_addr_t host_addr(input logic dsel, input dmem_waddr_t wa);
		return (32'(dsel) << `SOFTUSB_DSEL_BIT) | (32'(wa) << 2);
	endfunction

	// Expected host word from the address map.
	function automatic axil_data_t exp_read(input axil_addr_t addr);
		dmem_waddr_t wa;
		wa = addr[`SOFTUSB_DMEM_AW-1:2];
		if (addr[`SOFTUSB_DSEL_BIT])
			return {dmem_model[3][wa], dmem_model[2][wa], dmem_model[1][wa], dmem_model[0][wa]};
		else
			return {16'h0000, pmem_model[wa]};	// Zero upper half.
	endfunction

	task automatic model_write(input axil_addr_t addr, input axil_data_t d, input axil_strb_t s);
		dmem_waddr_t wa;
		wa = addr[`SOFTUSB_DMEM_AW-1:2];
		if (addr[`SOFTUSB_DSEL_BIT]) begin
			for (int g = 0; g < 4; g++)
				if (s[g])
					dmem_model[g][wa] = d[8*g +: 8];
		end else
			pmem_model[wa] = d[15:0];
	endtask

	task automatic wait_ready(input string who);
		int cnt;
		cnt = 0;
		while (!mem_ready) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > CLEAR_TIMEOUT)
				report_timeout(who);
		end
	endtask

	task automatic axil_write(input axil_addr_t addr, input axil_data_t d, input axil_strb_t s);
		int cnt;
		logic [31:0] r;
		logic done;
		@(negedge sys_clk);
		awaddr = addr;
		wdata = d;
		wstrb = s;
		awvalid = 1'b1;
		wvalid = 1'b1;
		cnt = 0;
		#1;
		while (!(awready && wready)) begin
			@(negedge sys_clk);
			#1;
			cnt++;
			if (cnt > TIMEOUT)
				report_timeout("write address and data handshake");
		end
		@(negedge sys_clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		model_write(addr, d, s);
		cnt = 0;
		done = 1'b0;
		while (!done) begin
			r = $urandom;
			bready = r[0];	// Random stall.
			#1;
			check_value(32'(bvalid), 32'd1, "bvalid held until bready");
			check_value(32'(bresp), 32'(RESP_OKAY), "write response code");
			done = bready;
			if (!done) begin
				@(negedge sys_clk);
				cnt++;
				if (cnt > TIMEOUT)
					report_timeout("write response");
			end
		end
		@(negedge sys_clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t d);
		int cnt;
		logic [31:0] r;
		logic done;
		axil_data_t held;
		@(negedge sys_clk);
		araddr = addr;
		arvalid = 1'b1;
		cnt = 0;
		#1;
		while (!arready) begin
			@(negedge sys_clk);
			#1;
			cnt++;
			if (cnt > TIMEOUT)
				report_timeout("read address handshake");
		end
		@(negedge sys_clk);
		arvalid = 1'b0;
		cnt = 0;
		done = 1'b0;
		held = '0;
		while (!done) begin
			r = $urandom;
			rready = r[0];
			#1;
			check_value(32'(rvalid), 32'd1, "rvalid held until rready");
			check_value(32'(rresp), 32'(RESP_OKAY), "read response code");
			if (cnt == 0)
				held = rdata;
			check_value(rdata, held, "rdata stable under back-pressure");
			done = rready;
			if (!done) begin
				@(negedge sys_clk);
				cnt++;
				if (cnt > TIMEOUT)
					report_timeout("read data");
			end
		end
		d = held;
		@(negedge sys_clk);
		rready = 1'b0;
	endtask

	task automatic core_fetch(input pmem_addr_t fa, output pmem_word_t fw);
		wait_ready("memory ready before a fetch");
		@(negedge sys_clk);
		pmem_a = fa;
		pmem_ce = 1'b1;
		@(negedge sys_clk);
		pmem_ce = 1'b0;
		fw = pmem_d;
	endtask

	task automatic core_wr(input dmem_addr_t ca, input dmem_byte_t cd);
		logic [1:0] lane;
		wait_ready("memory ready before a core write");
		@(negedge sys_clk);
		dmem_a = ca;
		dmem_di = cd;
		dmem_we = 1'b1;
		@(negedge sys_clk);
		dmem_we = 1'b0;
		lane = 2'd3 - ca[1:0];	// Offset 0 is the top lane.
		dmem_model[lane][ca[`SOFTUSB_DMEM_AW-1:2]] = cd;
	endtask

	task automatic core_rd(input dmem_addr_t ca, output dmem_byte_t cd);
		wait_ready("memory ready before a core read");
		@(negedge sys_clk);
		dmem_a = ca;
		dmem_we = 1'b0;
		@(negedge sys_clk);
		cd = dmem_do;
	endtask

	initial begin
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		pmem_ce = 1'b0;
		pmem_a = '0;
		dmem_we = 1'b0;
		dmem_a = '0;
		dmem_di = '0;
		rnd = $urandom(32'h775be204);	// Seed once.
		for (int i = 0; i < DWORDS; i++)
			for (int g = 0; g < 4; g++)
				dmem_model[g][i] = '0;	// State after the clear.

		n = 0;
		@(negedge sys_clk);
		#1;
		while (sys_rst) begin
			@(negedge sys_clk);
			#1;
			n++;
			if (n > 16)
				report_timeout("reset release");
		end
		check_value(32'({awready, wready, arready, bvalid, rvalid, mem_ready}), 32'd0,
			"control outputs after reset");
		n = 0;
		while (!mem_ready) begin
			@(negedge sys_clk);
			n++;
			if (n > CLEAR_TIMEOUT)
				report_timeout("the data memory clear");
		end
		check_value(32'(n), 32'd2048, "cycles until mem_ready");
		for (int i = 0; i < 32; i++) begin
			w = dmem_waddr_t'($urandom);
			axil_read(host_addr(1'b1, w), got);
			check_value(got, exp_read(host_addr(1'b1, w)), "cleared data word");
		end

		// Program memory over AXI and the fetch port.
		for (int i = 0; i < 8; i++) begin
			w = dmem_waddr_t'($urandom);
			data = $urandom;
			axil_write(host_addr(1'b0, w), data, 4'hF);
			axil_read(host_addr(1'b0, w), got);
			check_value(got, exp_read(host_addr(1'b0, w)), "program word over AXI");
			core_fetch(w, word);
			check_value(32'(word), 32'(pmem_model[w]), "program word at fetch port");
			for (int k = 0; k < 3; k++) begin
				@(negedge sys_clk);
				pmem_a = pmem_addr_t'($urandom);
				check_value(32'(pmem_d), 32'(pmem_model[w]), "fetch output hold");
			end
		end

		// Strobed merges on a few words.
		for (int i = 0; i < 32; i++) begin
			w = dmem_waddr_t'($urandom & 32'd7);
			axil_write(host_addr(1'b1, w), $urandom, axil_strb_t'($urandom));
			axil_read(host_addr(1'b1, w), got);
			check_value(got, exp_read(host_addr(1'b1, w)), "merged data word");
		end

		// Core byte port against AXI.
		for (int i = 0; i < 16; i++) begin
			a = dmem_addr_t'($urandom);
			core_wr(a, dmem_byte_t'($urandom));
			axil_read(host_addr(1'b1, a[`SOFTUSB_DMEM_AW-1:2]), got);
			check_value(got, exp_read(host_addr(1'b1, a[`SOFTUSB_DMEM_AW-1:2])),
				"core byte over AXI");
		end
		for (int i = 0; i < 8; i++) begin
			w = dmem_waddr_t'($urandom);
			axil_write(host_addr(1'b1, w), $urandom, 4'hF);
			for (int off = 0; off < 4; off++) begin
				core_rd(dmem_addr_t'({w, 2'(off)}), b);
				check_value(32'(b), 32'(dmem_model[3-off][w]), "AXI word at core port");
			end
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/softusb_pkg.sv
verilog/mem_access_if.sv
verilog/softusb_axil_fsm.sv
verilog/softusb_clear_timer.sv
verilog/softusb_pmem.sv
verilog/softusb_dmem.sv
verilog/softusb_ram_top.sv
verif/tb_clk_gen.sv
verif/tb_softusb_ram.sv

// File: Makefile
# Verilator simulation of the shared memory block.

VERILATOR ?= verilator
TOP ?= tb_softusb_ram
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
SIM_BIN ?= V$(TOP)

.PHONY: sim clean

# A failing run ends in $$fatal, so the binary's exit status reports it.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
